//--- mem_cfg.svh
// size and width constants of the banked on-chip RAM
// include this wherever bank count, depth or bus widths are needed
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// number of identical RAM banks behind the bus port
`define MEM_NUM_BANKS 4

// words held by one bank
`define MEM_BANK_WORDS 256

// bus data width in bits, a multiple of 8
`define MEM_DATA_W 32

// byte address width of the bus port
`define MEM_ADDR_W 32

`endif

//--- rtl/mem_pkg.sv
// bus and power types shared by the banked RAM modules
// refer to them by scoped name, for example mem_pkg::data_t
`default_nettype none

`include "mem_cfg.svh"

package mem_pkg;

  // a single bank still needs a one bit index
  localparam int unsigned BANK_IDX_W = (`MEM_NUM_BANKS > 1) ? $clog2(`MEM_NUM_BANKS) : 1;
  localparam int unsigned WORD_ADDR_W = $clog2(`MEM_BANK_WORDS);
  localparam int unsigned BE_W = `MEM_DATA_W / 8;

  typedef logic [BANK_IDX_W-1:0] bank_idx_t;
  typedef logic [WORD_ADDR_W-1:0] word_addr_t;
  typedef logic [`MEM_DATA_W-1:0] data_t;
  typedef logic [BE_W-1:0] be_t;

  // mode requested for a bank from the top level
  typedef enum logic [1:0] {
    PWR_ON        = 2'd0,
    PWR_RETENTIVE = 2'd1,
    PWR_OFF       = 2'd2
  } pwr_mode_e;

  // bank power sequencer states
  typedef enum logic [2:0] {
    ST_ON         = 3'd0,
    ST_ISO        = 3'd1,
    ST_RET        = 3'd2,
    ST_SWITCH_OFF = 3'd3,
    ST_OFF        = 3'd4,
    ST_SWITCH_ON  = 3'd5
  } pwr_state_e;

endpackage

`default_nettype wire

//--- rtl/bank_bus_if.sv
// request and response of one RAM bank inside the memory subsystem
// one instance per bank, shared by the decoder, the bank and the response mux
`default_nettype none

interface bank_bus_if;

  logic                 req;
  logic                 we;
  mem_pkg::be_t         be;
  mem_pkg::word_addr_t  addr;
  mem_pkg::data_t       wdata;
  logic                 gnt;
  logic                 rvalid;
  mem_pkg::data_t       rdata;

  modport decoder (
    output req,
    output we,
    output be,
    output addr,
    output wdata,
    input  gnt
  );

  modport bank (
    input  req,
    input  we,
    input  be,
    input  addr,
    input  wdata,
    output gnt,
    output rvalid,
    output rdata
  );

  // response side only
  modport collector (
    input rvalid,
    input rdata
  );

endinterface

`default_nettype wire

//--- rtl/bank_decoder.sv
// steers the bus request to one RAM bank by contiguous address ranges
// requests beyond the map are granted here and flagged as decode errors
`default_nettype none

`include "mem_cfg.svh"

module bank_decoder (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    req_i,
  input  logic                    we_i,
  input  mem_pkg::be_t            be_i,
  input  logic [`MEM_ADDR_W-1:0]  addr_i,
  input  mem_pkg::data_t          wdata_i,
  output logic                    gnt_o,
  bank_bus_if.decoder             banks [`MEM_NUM_BANKS-1:0],
  output logic                    sel_valid_o,
  output mem_pkg::bank_idx_t      sel_idx_o,
  output logic                    sel_err_o
);

  localparam int unsigned BYTE_OFF_W = $clog2(mem_pkg::BE_W);
  localparam logic [`MEM_ADDR_W-1:0] MAP_WORDS = `MEM_ADDR_W'(`MEM_NUM_BANKS * `MEM_BANK_WORDS);

  logic [`MEM_ADDR_W-1:0]       word_addr;
  logic                         in_range;
  mem_pkg::bank_idx_t           bank_idx;
  logic [`MEM_NUM_BANKS-1:0]    bank_req;
  logic [`MEM_NUM_BANKS-1:0]    bank_gnt;

  // drop the byte offset, then split into bank index and word index
  assign word_addr = addr_i >> BYTE_OFF_W;
  assign in_range  = word_addr < MAP_WORDS;
  assign bank_idx  = word_addr[mem_pkg::WORD_ADDR_W +: mem_pkg::BANK_IDX_W];

  for (genvar i = 0; i < `MEM_NUM_BANKS; i++) begin : g_bank
    assign bank_req[i] = req_i && in_range && (bank_idx == mem_pkg::bank_idx_t'(i));

    assign banks[i].req   = bank_req[i];
    assign banks[i].we    = we_i;
    assign banks[i].be    = be_i;
    assign banks[i].addr  = word_addr[mem_pkg::WORD_ADDR_W-1:0];
    assign banks[i].wdata = wdata_i;

    assign bank_gnt[i] = banks[i].gnt;
  end

  // unmapped addresses are answered locally in the same cycle
  assign gnt_o = req_i && (!in_range || bank_gnt[bank_idx]);

  assign sel_valid_o = req_i && gnt_o;
  assign sel_idx_o   = bank_idx;
  assign sel_err_o   = !in_range;

  // only the bank that was steered the request may take it
  a_one_bank_active : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(bank_gnt) && ((bank_gnt & ~bank_req) == '0)
  ) else $error("bank granted without its own request");

endmodule

`default_nettype wire

//--- rtl/ram_bank.sv
// one RAM bank with byte-enabled writes, registered reads and its power sequencer
// the bank always grants but only accesses storage while it is ON
`default_nettype none

`include "mem_cfg.svh"

module ram_bank (
  input  logic                clk_i,
  input  logic                rst_n_i,
  bank_bus_if.bank            bus,
  input  mem_pkg::pwr_mode_e  mode_i,
  output logic                switch_no,
  input  logic                switch_ack_ni,
  output logic                iso_no,
  output logic                retentive_no,
  output logic                on_o
);

  mem_pkg::data_t mem [`MEM_BANK_WORDS];

  mem_pkg::pwr_state_e state_q;
  mem_pkg::pwr_state_e state_d;

  logic is_on;

  // power sequencer
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      mem_pkg::ST_ON: begin
        if (mode_i == mem_pkg::PWR_RETENTIVE) begin
          state_d = mem_pkg::ST_RET;
        end else if (mode_i == mem_pkg::PWR_OFF) begin
          state_d = mem_pkg::ST_ISO;
        end
      end
      mem_pkg::ST_ISO: begin
        if (mode_i == mem_pkg::PWR_OFF) begin
          state_d = mem_pkg::ST_SWITCH_OFF;
        end else if (mode_i == mem_pkg::PWR_RETENTIVE) begin
          state_d = mem_pkg::ST_RET;
        end else begin
          state_d = mem_pkg::ST_ON;
        end
      end
      mem_pkg::ST_RET: begin
        // already isolated, so the switch may go off right away
        if (mode_i == mem_pkg::PWR_ON) begin
          state_d = mem_pkg::ST_ON;
        end else if (mode_i == mem_pkg::PWR_OFF) begin
          state_d = mem_pkg::ST_SWITCH_OFF;
        end
      end
      mem_pkg::ST_SWITCH_OFF: begin
        // the handshake completes before the mode is looked at again
        if (!switch_ack_ni) begin
          state_d = mem_pkg::ST_OFF;
        end
      end
      mem_pkg::ST_OFF: begin
        if (mode_i != mem_pkg::PWR_OFF) begin
          state_d = mem_pkg::ST_SWITCH_ON;
        end
      end
      mem_pkg::ST_SWITCH_ON: begin
        if (switch_ack_ni) begin
          if (mode_i == mem_pkg::PWR_ON) begin
            state_d = mem_pkg::ST_ON;
          end else if (mode_i == mem_pkg::PWR_RETENTIVE) begin
            state_d = mem_pkg::ST_RET;
          end else begin
            state_d = mem_pkg::ST_ISO;
          end
        end
      end
      default: state_d = mem_pkg::ST_ON;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= mem_pkg::ST_ON;
    end else begin
      state_q <= state_d;
    end
  end

  assign is_on        = state_q == mem_pkg::ST_ON;
  assign on_o         = is_on;
  assign iso_no       = is_on;
  assign retentive_no = state_q != mem_pkg::ST_RET;
  assign switch_no    = !(state_q inside {mem_pkg::ST_SWITCH_OFF, mem_pkg::ST_OFF});

  assign bus.gnt = bus.req;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      bus.rvalid <= 1'b0;
    end else begin
      bus.rvalid <= bus.req && bus.gnt;
    end
  end

  // byte lanes are written independently
  always_ff @(posedge clk_i) begin
    if (bus.req && bus.we && is_on) begin
      for (int b = 0; b < mem_pkg::BE_W; b++) begin
        if (bus.be[b]) begin
          mem[bus.addr][b*8 +: 8] <= bus.wdata[b*8 +: 8];
        end
      end
    end
  end

  // writes and isolated accesses return zero
  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      bus.rdata <= (!bus.we && is_on) ? mem[bus.addr] : '0;
    end
  end

  a_iso_before_switch : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $fell(switch_no) |-> $past(!iso_no)
  ) else $error("power switch opened while bank not isolated");

endmodule

`default_nettype wire

//--- rtl/bank_response_mux.sv
// merges the bank responses and decode errors into the single bus response
// the selection is captured at grant time and used one cycle later
`default_nettype none

`include "mem_cfg.svh"

module bank_response_mux (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       sel_valid_i,
  input  mem_pkg::bank_idx_t         sel_idx_i,
  input  logic                       sel_err_i,
  bank_bus_if.collector              banks [`MEM_NUM_BANKS-1:0],
  input  logic [`MEM_NUM_BANKS-1:0]  bank_on_i,
  output logic                       rvalid_o,
  output mem_pkg::data_t             rdata_o,
  output logic                       err_o
);

  logic               valid_q;
  mem_pkg::bank_idx_t idx_q;
  logic               dec_err_q;
  logic               on_q;
  logic               resp_err;

  logic [`MEM_NUM_BANKS-1:0] bank_rvalid;
  mem_pkg::data_t            bank_rdata [`MEM_NUM_BANKS];

  for (genvar i = 0; i < `MEM_NUM_BANKS; i++) begin : g_bank
    assign bank_rvalid[i] = banks[i].rvalid;
    assign bank_rdata[i]  = banks[i].rdata;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= sel_valid_i;
    end
  end

  // bank state is sampled together with the request
  always_ff @(posedge clk_i) begin
    if (sel_valid_i) begin
      idx_q     <= sel_idx_i;
      dec_err_q <= sel_err_i;
      on_q      <= bank_on_i[sel_idx_i];
    end
  end

  // an unmapped access has no bank response to wait for
  assign rvalid_o = valid_q && (dec_err_q || bank_rvalid[idx_q]);
  assign resp_err = dec_err_q || !on_q;
  assign err_o    = rvalid_o && resp_err;
  assign rdata_o  = (rvalid_o && !resp_err) ? bank_rdata[idx_q] : '0;

  a_resp_one_cycle : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    1'b1 |=> (rvalid_o == $past(sel_valid_i))
  ) else $error("response not exactly one cycle after grant");

endmodule

`default_nettype wire

//--- rtl/mem_subsystem.sv
// banked on-chip RAM with one OBI-style slave port and per-bank power control
// power switch, isolation and retention of every bank are exposed as plain vectors
`default_nettype none

`include "mem_cfg.svh"

module mem_subsystem (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,

  input  logic                                   req_i,
  input  logic                                   we_i,
  input  mem_pkg::be_t                           be_i,
  input  logic [`MEM_ADDR_W-1:0]                 addr_i,
  input  mem_pkg::data_t                         wdata_i,
  output logic                                   gnt_o,
  output logic                                   rvalid_o,
  output mem_pkg::data_t                         rdata_o,
  output logic                                   err_o,

  input  mem_pkg::pwr_mode_e [`MEM_NUM_BANKS-1:0] bank_mode_i,
  output logic [`MEM_NUM_BANKS-1:0]              bank_switch_no,
  input  logic [`MEM_NUM_BANKS-1:0]              bank_switch_ack_ni,
  output logic [`MEM_NUM_BANKS-1:0]              bank_iso_no,
  output logic [`MEM_NUM_BANKS-1:0]              bank_retentive_no
);

  logic                      sel_valid;
  mem_pkg::bank_idx_t        sel_idx;
  logic                      sel_err;
  logic [`MEM_NUM_BANKS-1:0] bank_on;

  bank_bus_if bank_bus [`MEM_NUM_BANKS-1:0] ();

  bank_decoder u_decoder (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (req_i),
    .we_i        (we_i),
    .be_i        (be_i),
    .addr_i      (addr_i),
    .wdata_i     (wdata_i),
    .gnt_o       (gnt_o),
    .banks       (bank_bus),
    .sel_valid_o (sel_valid),
    .sel_idx_o   (sel_idx),
    .sel_err_o   (sel_err)
  );

  // one bank and one power sequencer per address range
  for (genvar i = 0; i < `MEM_NUM_BANKS; i++) begin : g_bank
    ram_bank u_bank (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .bus           (bank_bus[i]),
      .mode_i        (bank_mode_i[i]),
      .switch_no     (bank_switch_no[i]),
      .switch_ack_ni (bank_switch_ack_ni[i]),
      .iso_no        (bank_iso_no[i]),
      .retentive_no  (bank_retentive_no[i]),
      .on_o          (bank_on[i])
    );
  end

  bank_response_mux u_resp_mux (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .sel_valid_i (sel_valid),
    .sel_idx_i   (sel_idx),
    .sel_err_i   (sel_err),
    .banks       (bank_bus),
    .bank_on_i   (bank_on),
    .rvalid_o    (rvalid_o),
    .rdata_o     (rdata_o),
    .err_o       (err_o)
  );

endmodule

`default_nettype wire

//--- bench/tb_mem_subsystem.sv
// testbench for the banked RAM subsystem with a power-switch model and reference memory
// compile with src.f and run tb_mem_subsystem as top module
`default_nettype none

`include "mem_cfg.svh"

module tb_mem_subsystem;

  localparam int NUM_OPS = 300;
  localparam int RESET_CYCLES = 16;
  localparam int TIMEOUT_CYCLES = NUM_OPS * 40 + RESET_CYCLES;
  localparam int MAP_WORDS = `MEM_NUM_BANKS * `MEM_BANK_WORDS;
  localparam int NUM_ADDR = 16;

  logic clk;
  logic rst_n;
  logic req;
  logic we;
  mem_pkg::be_t be;
  logic [`MEM_ADDR_W-1:0] addr;
  mem_pkg::data_t wdata;
  logic gnt_o;
  logic rvalid_o;
  mem_pkg::data_t rdata_o;
  logic err_o;
  mem_pkg::pwr_mode_e [`MEM_NUM_BANKS-1:0] bank_mode;
  logic [`MEM_NUM_BANKS-1:0] bank_switch_no;
  logic [`MEM_NUM_BANKS-1:0] sw_ack;
  logic [`MEM_NUM_BANKS-1:0] bank_iso_no;
  logic [`MEM_NUM_BANKS-1:0] bank_retentive_no;

  integer seed = 24045;
  int sw_cnt [`MEM_NUM_BANKS];
  mem_pkg::data_t ref_mem [MAP_WORDS];
  logic ref_on [`MEM_NUM_BANKS];
  logic [`MEM_DATA_W:0] exp_q [$];
  logic [`MEM_DATA_W:0] exp_resp;
  logic checking;
  logic [`MEM_ADDR_W-1:0] addr_list [NUM_ADDR];

  mem_subsystem dut (
    .clk_i              (clk),
    .rst_n_i            (rst_n),
    .req_i              (req),
    .we_i               (we),
    .be_i               (be),
    .addr_i             (addr),
    .wdata_i            (wdata),
    .gnt_o              (gnt_o),
    .rvalid_o           (rvalid_o),
    .rdata_o            (rdata_o),
    .err_o              (err_o),
    .bank_mode_i        (bank_mode),
    .bank_switch_no     (bank_switch_no),
    .bank_switch_ack_ni (sw_ack),
    .bank_iso_no        (bank_iso_no),
    .bank_retentive_no  (bank_retentive_no)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("TEST FAIL");
      $fatal(1, "check failed");
    end
  endtask

  // expected {err, rdata}; a write updates the reference memory
  function automatic logic [`MEM_DATA_W:0] ref_access(input logic op_we, input mem_pkg::be_t op_be,
      input logic [`MEM_ADDR_W-1:0] op_addr, input mem_pkg::data_t op_data);
    int word;
    int bank;
    word = int'(op_addr >> 2);
    if (op_addr >= MAP_WORDS * 4) return {1'b1, {`MEM_DATA_W{1'b0}}};
    bank = word / `MEM_BANK_WORDS;
    if (!ref_on[bank]) return {1'b1, {`MEM_DATA_W{1'b0}}};
    if (!op_we) return {1'b0, ref_mem[word]};
    for (int b = 0; b < `MEM_DATA_W / 8; b++) begin
      if (op_be[b]) ref_mem[word][b*8 +: 8] = op_data[b*8 +: 8];
    end
    return {1'b0, {`MEM_DATA_W{1'b0}}};
  endfunction

  // the switch acknowledge follows the command after 1 to 8 cycles
  always @(negedge clk) begin
    for (int b = 0; b < `MEM_NUM_BANKS; b++) begin
      if (sw_ack[b] == bank_switch_no[b]) begin
        sw_cnt[b] = 0;
      end else if (sw_cnt[b] == 0) begin
        sw_cnt[b] = 1 + ($unsigned($random(seed)) % 8);
      end else begin
        sw_cnt[b] = sw_cnt[b] - 1;
        if (sw_cnt[b] == 0) sw_ack[b] <= bank_switch_no[b];
      end
    end
  end

  // every granted transfer answers at the next falling edge
  always @(negedge clk) begin
    if (checking) begin
      if (exp_q.size() != 0) begin
        exp_resp = exp_q.pop_front();
        check_value("rvalid_o", rvalid_o, 1);
        check_value("err_o", err_o, exp_resp[`MEM_DATA_W]);
        check_value("rdata_o", rdata_o, exp_resp[`MEM_DATA_W-1:0]);
      end else begin
        check_value("rvalid_o", rvalid_o, 0);
      end
    end
  end

  initial begin
    #(TIMEOUT_CYCLES * 20);
    $display("timeout: the test did not finish in time");
    $display("TEST FAIL");
    $fatal(1, "watchdog expired");
  end

  // called at a falling edge, returns at the next one
  task automatic issue(input logic op_we, input mem_pkg::be_t op_be,
      input logic [`MEM_ADDR_W-1:0] op_addr, input mem_pkg::data_t op_data);
    req = 1'b1;
    we = op_we;
    be = op_be;
    addr = op_addr;
    wdata = op_data;
    #5;
    check_value("gnt_o", gnt_o, 1);
    exp_q.push_back(ref_access(op_we, op_be, op_addr, op_data));
    @(negedge clk);
  endtask

  task automatic idle(input int n);
    req = 1'b0;
    we = 1'b0;
    repeat (n) @(negedge clk);
  endtask

  function automatic logic [`MEM_ADDR_W-1:0] bank_addr(input int b, input int w);
    return (b * `MEM_BANK_WORDS + w) * 4;
  endfunction

  task automatic power_cycle(input int b, input int other);
    bank_mode[b] = mem_pkg::PWR_OFF;
    ref_on[b] = 1'b0;
    idle(1);
    check_value("bank_iso_no", bank_iso_no[b], 0);
    check_value("bank_switch_no", bank_switch_no[b], 1);
    while (sw_ack[b] !== 1'b0) begin
      if (!bank_switch_no[b]) check_value("bank_iso_no", bank_iso_no[b], 0);
      issue(1'b0, '1, bank_addr(b, 3), '0);
      issue(1'b1, '1, addr_list[other], $random(seed));
    end
    idle(2);
    check_value("bank_switch_no", bank_switch_no[b], 0);
    issue(1'b1, '1, bank_addr(b, 7), 32'h1234_5678);
    bank_mode[b] = mem_pkg::PWR_ON;
    idle(1);
    while (!bank_iso_no[b]) begin
      check_value("bank_switch_no", bank_switch_no[b], 1);
      issue(1'b0, '1, bank_addr(b, 5), '0);
      issue(1'b0, '1, addr_list[other], '0);
    end
    check_value("bank_switch_ack_ni", sw_ack[b], 1);
    ref_on[b] = 1'b1;
  endtask

  initial begin
    rst_n = 1'b0;
    req = 1'b0;
    we = 1'b0;
    be = '0;
    addr = '0;
    wdata = '0;
    checking = 1'b0;
    sw_ack = '1;
    for (int b = 0; b < `MEM_NUM_BANKS; b++) begin
      bank_mode[b] = mem_pkg::PWR_ON;
      ref_on[b] = 1'b1;
      sw_cnt[b] = 0;
    end
    for (int i = 0; i < NUM_ADDR; i++) begin
      addr_list[i] = bank_addr(i % `MEM_NUM_BANKS, $unsigned($random(seed)) % `MEM_BANK_WORDS);
    end
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_value("gnt_o", gnt_o, 0);
    check_value("rvalid_o", rvalid_o, 0);
    check_value("err_o", err_o, 0);
    check_value("bank_switch_no", bank_switch_no, {`MEM_NUM_BANKS{1'b1}});
    check_value("bank_iso_no", bank_iso_no, {`MEM_NUM_BANKS{1'b1}});
    check_value("bank_retentive_no", bank_retentive_no, {`MEM_NUM_BANKS{1'b1}});
    checking = 1'b1;

    // full words first, then partial writes, then reads
    for (int i = 0; i < NUM_ADDR; i++) issue(1'b1, '1, addr_list[i], $random(seed));
    for (int i = 0; i < NUM_ADDR; i++) begin
      issue(1'b1, $random(seed), addr_list[i], $random(seed));
    end
    for (int i = 0; i < NUM_ADDR; i++) issue(1'b0, '0, addr_list[i], '0);

    // beyond the map end on aliases of mapped words that are read back below
    issue(1'b1, '1, MAP_WORDS * 4 + addr_list[0], 32'hdead_beef);
    issue(1'b1, '1, MAP_WORDS * 4 + addr_list[1], 32'hcafe_f00d);
    issue(1'b1, '1, addr_list[3] | 32'hffff_f000, 32'h5555_aaaa);
    issue(1'b0, '0, MAP_WORDS * 4, '0);
    for (int i = 0; i < NUM_ADDR; i++) issue(1'b0, '0, addr_list[i], '0);
    idle(1);

    // retention keeps bank 1
    bank_mode[1] = mem_pkg::PWR_RETENTIVE;
    ref_on[1] = 1'b0;
    idle(2);
    check_value("bank_iso_no", bank_iso_no[1], 0);
    check_value("bank_retentive_no", bank_retentive_no[1], 0);
    check_value("bank_switch_no", bank_switch_no[1], 1);
    issue(1'b1, '1, addr_list[1], 32'h0bad_0bad);
    issue(1'b0, '0, addr_list[5], '0);
    issue(1'b0, '0, addr_list[0], '0);
    bank_mode[1] = mem_pkg::PWR_ON;
    idle(2);
    check_value("bank_iso_no", bank_iso_no[1], 1);
    check_value("bank_retentive_no", bank_retentive_no[1], 1);
    ref_on[1] = 1'b1;
    for (int i = 1; i < NUM_ADDR; i += `MEM_NUM_BANKS) issue(1'b0, '0, addr_list[i], '0);

    // bank 2 off and back while bank 0 keeps working
    power_cycle(2, 0);
    for (int i = 2; i < NUM_ADDR; i += `MEM_NUM_BANKS) issue(1'b1, '1, addr_list[i], $random(seed));
    for (int i = 0; i < NUM_ADDR; i++) issue(1'b0, '0, addr_list[i], '0);
    idle(3);

    if (exp_q.size() != 0) begin
      $display("responses missing at the end of the test");
      $display("TEST FAIL");
      $fatal(1, "missing responses");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+.
rtl/mem_pkg.sv
rtl/bank_bus_if.sv
rtl/bank_decoder.sv
rtl/ram_bank.sv
rtl/bank_response_mux.sv
rtl/mem_subsystem.sv
bench/tb_mem_subsystem.sv

//--- run.sh
#!/bin/sh
# build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module tb_mem_subsystem -o sim_tb
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation returned status $status"
  exit 1
fi

if echo "$out" | grep -q "TEST PASS"; then
  exit 0
fi
exit 1
